// File: tb.f
fpga_pkg.sv
sync_reset.sv
uart_rx.sv
uart_tx.sv
port_led_ctrl.sv
fpga_core.sv
fpga.sv
tb_fpga.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_fpga -f tb.f -o tb_fpga_sim \
    || exit 1
./obj_dir/tb_fpga_sim | tee /dev/stderr | grep "Regression passed" > /dev/null \
    && exit 0 || exit 1

// File: tb_fpga.sv
// FPGA board testbench

`timescale 1ns/100ps

module tb_fpga;

import fpga_pkg::*;

typedef logic [PORT_CNT-1:0] led_vec_t;

// One stimulus row, expected echo alongside
typedef struct packed {
    logic [1:0] chan;
    logic       all_ch;
    logic       rand_byte;
    uart_byte_t data;
    logic       stop_ok;
    logic       echo_en;
    uart_byte_t exp_data;
} stim_t;

localparam int CLK_PERIOD = 20;
localparam int RESET_CYCLES = 8;
localparam int TABLE_LEN = 10;
localparam int ECHO_WAIT = 12 * CLKS_PER_BIT;
localparam int WATCHDOG_NS = (TABLE_LEN * 12 * 10 * CLKS_PER_BIT + RESET_CYCLES) * CLK_PERIOD;

logic      clk_125mhz;
logic      rst_n;
uart_vec_t uart_rxd;
uart_vec_t uart_txd;
led_vec_t  qsfp_led_act;
led_vec_t  qsfp_led_stat_g;
led_vec_t  qsfp_led_stat_y;
logic      hbm_cattrip;

stim_t      stim_tbl [TABLE_LEN];
uart_byte_t echo_q [UART_CNT][$];
led_vec_t   act_q [UART_CNT][$];
led_vec_t   y_exp;
int         seed = 79098;
int         test_err;
int         pass_cnt;
int         fail_cnt;

fpga i_fpga (
    .clk_125mhz(clk_125mhz),
    .rst_n(rst_n),
    .uart_rxd(uart_rxd),
    .uart_txd(uart_txd),
    .qsfp_led_act(qsfp_led_act),
    .qsfp_led_stat_g(qsfp_led_stat_g),
    .qsfp_led_stat_y(qsfp_led_stat_y),
    .hbm_cattrip(hbm_cattrip)
);

initial begin
    clk_125mhz = 1'b0;
    forever #(CLK_PERIOD/2) clk_125mhz = ~clk_125mhz;
end

initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
end

task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string msg);
    if (got !== exp) begin
        $display("CHECK FAILED %0t: %s got %02h expected %02h", $time, msg, got, exp);
        test_err++;
    end
endtask

task automatic check_led(input led_vec_t got, input led_vec_t exp, input string msg);
    if (got !== exp) begin
        $display("CHECK FAILED %0t: %s got %b expected %b", $time, msg, got, exp);
        test_err++;
    end
endtask

task automatic check_vec(input uart_vec_t got, input uart_vec_t exp, input string msg);
    if (got !== exp) begin
        $display("CHECK FAILED %0t: %s got %b expected %b", $time, msg, got, exp);
        test_err++;
    end
endtask

task automatic finish_test(input string name);
    if (test_err == 0) begin
        pass_cnt++;
        $display("%s: ok", name);
    end else begin
        fail_cnt++;
        $display("%s: %0d error(s)", name, test_err);
    end
endtask

// Distinct byte per channel for simultaneous frames
function automatic uart_byte_t spread_byte(input uart_byte_t b, input int k);
    return b ^ uart_byte_t'(k * 8'h11);
endfunction

function automatic uart_vec_t echo_mask();
    uart_vec_t m;
    m = '0;
    for (int k = 0; k < UART_CNT; k++) begin
        m[k] = (echo_q[k].size() != 0);
    end
    return m;
endfunction

// Start, eight data bits LSB first, stop
task automatic send_byte(input int ch, input uart_byte_t b, input logic stop_ok);
    int i;
    @(negedge clk_125mhz);
    uart_rxd[ch] = 1'b0;
    repeat (CLKS_PER_BIT) @(negedge clk_125mhz);
    for (i = 0; i < 8; i++) begin
        uart_rxd[ch] = b[i];
        repeat (CLKS_PER_BIT) @(negedge clk_125mhz);
    end
    uart_rxd[ch] = stop_ok;
    repeat (CLKS_PER_BIT) @(negedge clk_125mhz);
    uart_rxd[ch] = 1'b1;
endtask

// Decodes one txd line, sampling each bit near its middle
task automatic monitor_txd(input int ch);
    uart_byte_t d;
    int i;
    forever begin
        @(negedge clk_125mhz);
        if (uart_txd[ch] === 1'b0) begin
            act_q[ch].push_back(qsfp_led_act);
            repeat (CLKS_PER_BIT/2) @(negedge clk_125mhz);
            for (i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk_125mhz);
                d[i] = uart_txd[ch];
            end
            repeat (CLKS_PER_BIT) @(negedge clk_125mhz);
            if (uart_txd[ch] !== 1'b1) begin
                $display("Stop bit missing on txd of channel %0d at %0t", ch, $time);
                test_err++;
            end
            echo_q[ch].push_back(d);
        end
    end
endtask

initial begin
    fork
        monitor_txd(0);
        monitor_txd(1);
        monitor_txd(2);
    join
end

task automatic fill_table();
    int t;
    stim_tbl[0] = '{2'd0, 1'b0, 1'b0, 8'h55, 1'b1, 1'b1, 8'h55};
    stim_tbl[1] = '{2'd1, 1'b0, 1'b0, 8'hA3, 1'b1, 1'b1, 8'hA3};
    stim_tbl[2] = '{2'd2, 1'b0, 1'b1, 8'h00, 1'b1, 1'b1, 8'h00};
    stim_tbl[3] = '{2'd0, 1'b1, 1'b0, 8'h3C, 1'b1, 1'b1, 8'h3C};
    stim_tbl[4] = '{2'd1, 1'b0, 1'b0, 8'hF0, 1'b0, 1'b0, 8'h00};
    stim_tbl[5] = '{2'd1, 1'b0, 1'b0, 8'h0F, 1'b1, 1'b1, 8'h0F};
    stim_tbl[6] = '{2'd0, 1'b0, 1'b1, 8'h00, 1'b1, 1'b1, 8'h00};
    stim_tbl[7] = '{2'd0, 1'b1, 1'b1, 8'h00, 1'b1, 1'b1, 8'h00};
    stim_tbl[8] = '{2'd2, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 8'h00};
    stim_tbl[9] = '{2'd2, 1'b0, 1'b0, 8'hFF, 1'b1, 1'b1, 8'hFF};
    for (t = 0; t < TABLE_LEN; t++) begin
        if (stim_tbl[t].rand_byte) begin
            stim_tbl[t].data = uart_byte_t'($random(seed));
            stim_tbl[t].exp_data = stim_tbl[t].data;
        end
    end
endtask

task automatic run_entry(input int t);
    stim_t      e;
    uart_vec_t  exp_mask;
    uart_byte_t exp_b;
    int         wait_cnt;
    int         gap;
    int         k;
    e = stim_tbl[t];
    test_err = 0;
    exp_mask = '0;
    if (e.echo_en) begin
        exp_mask = e.all_ch ? '1 : uart_vec_t'(1) << e.chan;
    end
    if (e.all_ch) begin
        fork
            send_byte(0, spread_byte(e.data, 0), e.stop_ok);
            send_byte(1, spread_byte(e.data, 1), e.stop_ok);
            send_byte(2, spread_byte(e.data, 2), e.stop_ok);
        join
    end else begin
        send_byte(int'(e.chan), e.data, e.stop_ok);
    end
    // Bad frames wait out the whole window to prove silence
    wait_cnt = 0;
    while (!(exp_mask != '0 && echo_mask() == exp_mask) && wait_cnt < ECHO_WAIT) begin
        @(negedge clk_125mhz);
        wait_cnt++;
    end
    for (k = 0; k < UART_CNT; k++) begin
        if (exp_mask[k] && echo_q[k].size() == 0) begin
            $display("No byte came back on channel %0d at %0t", k, $time);
            test_err++;
        end
    end
    check_vec(echo_mask() & ~exp_mask, '0, "echo on a channel that received nothing");
    for (k = 0; k < UART_CNT; k++) begin
        exp_b = e.all_ch ? spread_byte(e.exp_data, k) : e.exp_data;
        while (echo_q[k].size() != 0) begin
            check_byte(echo_q[k].pop_front(), exp_b, "echoed byte");
            check_led(act_q[k].pop_front(), '1, "activity LED at echo start");
        end
    end
    if (!e.stop_ok) begin
        y_exp = '1;
    end
    check_led(qsfp_led_stat_y, y_exp, "error LED");
    gap = CLKS_PER_BIT * (1 + ($random(seed) & 3));
    repeat (gap) @(negedge clk_125mhz);
    finish_test($sformatf("entry %0d %s", t, e.stop_ok ? "good frame" : "bad stop bit"));
endtask

initial begin
    int t;
    rst_n = 1'b0;
    uart_rxd = '1;
    y_exp = '0;
    pass_cnt = 0;
    fail_cnt = 0;
    test_err = 0;
    fill_table();

    repeat (RESET_CYCLES) @(negedge clk_125mhz);
    check_vec(uart_txd, '1, "txd idle in reset");
    check_led(qsfp_led_act, '0, "activity LED in reset");
    check_led(qsfp_led_stat_y, '0, "error LED in reset");
    check_led(qsfp_led_stat_g, '0, "green LED in reset");
    check_led({PORT_CNT{hbm_cattrip}}, '0, "thermal trip");
    rst_n = 1'b1;
    // Green follows the synchronizer release by one clock
    repeat (RST_SYNC_STAGES) @(negedge clk_125mhz);
    check_led(qsfp_led_stat_g, '0, "green LED before core release");
    @(negedge clk_125mhz);
    check_led(qsfp_led_stat_g, '1, "green LED after core release");
    finish_test("reset state");

    for (t = 0; t < TABLE_LEN; t++) begin
        run_entry(t);
    end

    test_err = 0;
    repeat (ACT_HOLD_CYCLES + CLKS_PER_BIT) @(negedge clk_125mhz);
    check_led(qsfp_led_act, '0, "activity LED after idle");
    check_led(qsfp_led_stat_y, y_exp, "error LED held");
    check_vec(uart_txd, '1, "txd idle at end");
    finish_test("activity timeout");

    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

endmodule

// File: fpga.sv
// FPGA board top level

`resetall
`timescale 1ns/100ps
`default_nettype none

module fpga (
    input  wire logic                          clk_125mhz,
    input  wire logic                          rst_n,

    // UART
    input  wire fpga_pkg::uart_vec_t           uart_rxd,
    output wire fpga_pkg::uart_vec_t           uart_txd,

    // GPIO
    output wire logic [fpga_pkg::PORT_CNT-1:0] qsfp_led_act,
    output wire logic [fpga_pkg::PORT_CNT-1:0] qsfp_led_stat_g,
    output wire logic [fpga_pkg::PORT_CNT-1:0] qsfp_led_stat_y,
    output wire logic                          hbm_cattrip
);

wire core_rst_n;

sync_reset sync_reset_inst (
    .clk_125mhz(clk_125mhz),
    .rst_n(rst_n),
    .core_rst_n(core_rst_n)
);

// No thermal sensing here, keep the trip line inactive
assign hbm_cattrip = 1'b0;

fpga_core core_inst (
    .clk_125mhz(clk_125mhz),
    .rst_n(core_rst_n),
    .uart_rxd(uart_rxd),
    .uart_txd(uart_txd),
    .port_led_act(qsfp_led_act),
    .port_led_stat_g(qsfp_led_stat_g),
    .port_led_stat_y(qsfp_led_stat_y)
);

endmodule

`resetall

// File: fpga_core.sv
// FPGA core logic

`resetall
`timescale 1ns/100ps
`default_nettype none

module fpga_core (
    input  wire logic                          clk_125mhz,
    input  wire logic                          rst_n,
    input  wire fpga_pkg::uart_vec_t           uart_rxd,
    output wire fpga_pkg::uart_vec_t           uart_txd,
    output wire logic [fpga_pkg::PORT_CNT-1:0] port_led_act,
    output wire logic [fpga_pkg::PORT_CNT-1:0] port_led_stat_g,
    output wire logic [fpga_pkg::PORT_CNT-1:0] port_led_stat_y
);

import fpga_pkg::*;

uart_vec_t rx_valid;
uart_vec_t rx_ready;
uart_vec_t tx_valid;
uart_vec_t tx_ready;
uart_vec_t rx_event;
uart_vec_t rx_error;

// One echo loop per UART channel
for (genvar n = 0; n < UART_CNT; n++) begin : g_uart
    rx_byte_t rx_word;

    uart_rx rx_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n(rst_n),
        .rxd(uart_rxd[n]),
        .rx_valid(rx_valid[n]),
        .rx_byte(rx_word),
        .rx_ready(rx_ready[n]),
        .rx_done(rx_event[n])
    );

    // Bad frames are drained here and never reach the transmitter
    assign tx_valid[n] = rx_valid[n] && !rx_word.frame_err;
    assign rx_ready[n] = tx_ready[n] || rx_word.frame_err;
    assign rx_error[n] = rx_valid[n] && rx_ready[n] && (rx_word.frame_err || rx_word.overrun);

    uart_tx tx_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n(rst_n),
        .tx_valid(tx_valid[n]),
        .tx_data(rx_word.data),
        .tx_ready(tx_ready[n]),
        .txd(uart_txd[n])
    );
end

port_led_ctrl led_ctrl_inst (
    .clk_125mhz(clk_125mhz),
    .rst_n(rst_n),
    .rx_event(rx_event),
    .rx_error(rx_error),
    .led_act(port_led_act),
    .led_stat_g(port_led_stat_g),
    .led_stat_y(port_led_stat_y)
);

endmodule

`resetall

// File: port_led_ctrl.sv
// Port LED controller

`resetall
`timescale 1ns/100ps
`default_nettype none

module port_led_ctrl (
    input  wire logic                          clk_125mhz,
    input  wire logic                          rst_n,
    input  wire fpga_pkg::uart_vec_t           rx_event,
    input  wire fpga_pkg::uart_vec_t           rx_error,
    output wire logic [fpga_pkg::PORT_CNT-1:0] led_act,
    output logic [fpga_pkg::PORT_CNT-1:0]      led_stat_g,
    output logic [fpga_pkg::PORT_CNT-1:0]      led_stat_y
);

import fpga_pkg::*;

act_cnt_t act_cnt;

// Activity stretch, restarted by every received byte
always_ff @(posedge clk_125mhz or negedge rst_n) begin
    if (!rst_n) begin
        act_cnt <= '0;
    end else if (|rx_event) begin
        act_cnt <= act_cnt_t'(ACT_HOLD_CYCLES);
    end else if (act_cnt != '0) begin
        act_cnt <= act_cnt - 1'b1;
    end
end

assign led_act = {PORT_CNT{act_cnt != '0}};

// Green comes up with the core, yellow holds any error
always_ff @(posedge clk_125mhz or negedge rst_n) begin
    if (!rst_n) begin
        led_stat_g <= '0;
        led_stat_y <= '0;
    end else begin
        led_stat_g <= '1;
        if (|rx_error) begin
            led_stat_y <= '1;
        end
    end
end

endmodule

`resetall

// File: uart_tx.sv
// UART transmitter

`resetall
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
    input  wire logic                 clk_125mhz,
    input  wire logic                 rst_n,
    input  wire logic                 tx_valid,
    input  wire fpga_pkg::uart_byte_t tx_data,
    output wire logic                 tx_ready,
    output logic                      txd
);

import fpga_pkg::*;

tx_state_t  state;
bit_tick_t  tick_cnt;
bit_idx_t   bit_idx;
uart_byte_t shift_reg;
logic       tick_last;

assign tick_last = (tick_cnt == bit_tick_t'(CLKS_PER_BIT-1));
// Busy from acceptance through the end of the stop bit
assign tx_ready = (state == TX_IDLE);

always_ff @(posedge clk_125mhz or negedge rst_n) begin
    if (!rst_n) begin
        state <= TX_IDLE;
        tick_cnt <= '0;
        bit_idx <= '0;
        txd <= 1'b1;
    end else begin
        if (state == TX_IDLE || tick_last) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
        case (state)
            TX_IDLE: begin
                if (tx_valid) begin
                    state <= TX_START;
                    txd <= 1'b0;
                end
            end
            TX_START: begin
                if (tick_last) begin
                    state <= TX_DATA;
                    bit_idx <= '0;
                    txd <= shift_reg[0];
                end
            end
            TX_DATA: begin
                if (tick_last) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == bit_idx_t'(7)) begin
                        state <= TX_STOP;
                        txd <= 1'b1;
                    end else begin
                        txd <= shift_reg[0];
                    end
                end
            end
            TX_STOP: begin
                if (tick_last) begin
                    state <= TX_IDLE;
                end
            end
            default: state <= TX_IDLE;
        endcase
    end
end

// Next data bit always sits in bit 0
always_ff @(posedge clk_125mhz) begin
    if (tx_valid && tx_ready) begin
        shift_reg <= tx_data;
    end else if (tick_last && (state == TX_START || state == TX_DATA)) begin
        shift_reg <= shift_reg >> 1;
    end
end

endmodule

`resetall

// File: uart_rx.sv
// UART receiver

`resetall
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  wire logic          clk_125mhz,
    input  wire logic          rst_n,
    input  wire logic          rxd,
    output logic               rx_valid,
    output fpga_pkg::rx_byte_t rx_byte,
    input  wire logic          rx_ready,
    output logic               rx_done
);

import fpga_pkg::*;

rx_state_t  state;
bit_tick_t  tick_cnt;
bit_idx_t   bit_idx;
uart_byte_t shift_reg;
logic       rxd_meta;
logic       rxd_sync;
logic       rxd_prev;
logic       overrun_pend;
logic       tick_half;
logic       tick_last;
logic       stop_sample;
logic       out_free;

assign tick_half = (tick_cnt == bit_tick_t'(CLKS_PER_BIT/2-1));
assign tick_last = (tick_cnt == bit_tick_t'(CLKS_PER_BIT-1));
assign stop_sample = (state == RX_STOP) && tick_last;
// Output slot is empty or drains this cycle
assign out_free = !rx_valid || rx_ready;

// Two-flop synchronizer plus edge history
always_ff @(posedge clk_125mhz or negedge rst_n) begin
    if (!rst_n) begin
        rxd_meta <= 1'b1;
        rxd_sync <= 1'b1;
        rxd_prev <= 1'b1;
    end else begin
        rxd_meta <= rxd;
        rxd_sync <= rxd_meta;
        rxd_prev <= rxd_sync;
    end
end

always_ff @(posedge clk_125mhz or negedge rst_n) begin
    if (!rst_n) begin
        state <= RX_IDLE;
        tick_cnt <= '0;
        bit_idx <= '0;
    end else begin
        case (state)
            RX_IDLE: begin
                tick_cnt <= '0;
                // Falling edge starts a frame
                if (rxd_prev && !rxd_sync) begin
                    state <= RX_START;
                end
            end
            RX_START: begin
                if (tick_half) begin
                    tick_cnt <= '0;
                    bit_idx <= '0;
                    // Line back high at mid start bit means a glitch
                    state <= rxd_sync ? RX_IDLE : RX_DATA;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
            RX_DATA: begin
                if (tick_last) begin
                    tick_cnt <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == bit_idx_t'(7)) begin
                        state <= RX_STOP;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
            RX_STOP: begin
                if (tick_last) begin
                    tick_cnt <= '0;
                    state <= RX_IDLE;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
            default: state <= RX_IDLE;
        endcase
    end
end

// LSB arrives first
always_ff @(posedge clk_125mhz) begin
    if (state == RX_DATA && tick_last) begin
        shift_reg <= {rxd_sync, shift_reg[7:1]};
    end
end

always_ff @(posedge clk_125mhz or negedge rst_n) begin
    if (!rst_n) begin
        rx_valid <= 1'b0;
        rx_done <= 1'b0;
        overrun_pend <= 1'b0;
    end else begin
        rx_done <= stop_sample;
        if (stop_sample && out_free) begin
            rx_valid <= 1'b1;
            overrun_pend <= 1'b0;
        end else begin
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            // Byte lost, flag it on the next one
            if (stop_sample) begin
                overrun_pend <= 1'b1;
            end
        end
    end
end

always_ff @(posedge clk_125mhz) begin
    if (stop_sample && out_free) begin
        rx_byte.data <= shift_reg;
        rx_byte.frame_err <= !rxd_sync;
        rx_byte.overrun <= overrun_pend;
    end
end

endmodule

`resetall

// File: sync_reset.sv
// Core reset synchronizer

`resetall
`timescale 1ns/100ps
`default_nettype none

module sync_reset (
    input  wire logic  clk_125mhz,
    input  wire logic  rst_n,
    output wire logic  core_rst_n
);

import fpga_pkg::*;

logic [RST_SYNC_STAGES-1:0] sync_reg;

// Clears at once, fills with ones on the clock
always_ff @(posedge clk_125mhz or negedge rst_n) begin
    if (!rst_n) begin
        sync_reg <= '0;
    end else begin
        sync_reg <= {sync_reg[RST_SYNC_STAGES-2:0], 1'b1};
    end
end

assign core_rst_n = sync_reg[RST_SYNC_STAGES-1];

endmodule

`resetall

// File: fpga_pkg.sv
// Board and UART definitions

package fpga_pkg;

// Board configuration
localparam int UART_CNT = 3;
localparam int PORT_CNT = 1;

// Short bit period keeps simulation fast
localparam int CLKS_PER_BIT = 16;

// Activity LED hold time after the last received byte
localparam int ACT_HOLD_CYCLES = 256;

// Reset release chain length
localparam int RST_SYNC_STAGES = 4;

typedef logic [7:0] uart_byte_t;
typedef logic [UART_CNT-1:0] uart_vec_t;

// Counters for bit timing and LED hold
typedef logic [$clog2(CLKS_PER_BIT)-1:0] bit_tick_t;
typedef logic [2:0] bit_idx_t;
typedef logic [$clog2(ACT_HOLD_CYCLES+1)-1:0] act_cnt_t;

// Received character with status
typedef struct packed {
    uart_byte_t data;
    logic       frame_err;
    logic       overrun;
} rx_byte_t;

typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
} rx_state_t;

typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
} tx_state_t;

endpackage
